// File: build.f
hw/bootPkg.sv
hw/SpiReader.sv
hw/BootImage.sv
hw/MemController.sv
hw/MappedRegisters.sv
hw/UProc.sv
tests/spiEepromModel.sv
tests/tbUProc.sv

// File: tests/tbUProc.sv
// Testbench for UProc. Boots a random image, drives the core port and pause,
// then reboots from an image with a bad magic. Assertions do all checking.
// Expected register and read data follow the one- and two-cycle port timing.
`timescale 1ns/100ps
`default_nettype none

module tbUProc import bootPkg::*; ();

	localparam int SPI_CLK_DIV = 2;
	localparam int MAP_REGS    = 16;
	localparam int IDX_W       = $clog2(MAP_REGS);
	localparam int WORDS       = 24;
	localparam int DEPTH       = 64;
	// Both boots in SPI bytes including opcode and address.
	localparam int BOOT_BYTES  = (3 + 2 * (WORDS + 1)) + (3 + 2);
	localparam int LIMIT       = BOOT_BYTES * 16 * SPI_CLK_DIV + 2000;

	typedef struct packed {
		logic             valid;
		logic [IDX_W-1:0] idx;
		logic [15:0]      data;
	} regOp_t;

	logic        clk;
	logic        rstN;
	logic        spiClk;
	logic        spiMosi;
	logic        spiMiso;
	logic        spiCsN;
	logic        doPause;
	memReq_t     coreReq;
	logic [15:0] memData;
	memReq_t     memReq;
	logic [15:0] coreRdata;
	logic        coreRvalid;
	logic        isBooted;
	logic        isPaused;
	logic        bootFail;
	logic [15:0] gpioPins;

	// Scoreboard and reference state.
	logic [15:0] expWords [WORDS];
	logic [15:0] shadow [MAP_REGS];
	int          expCount;
	logic        expFail;
	int          wrCnt;
	logic        bootedQ;
	logic        accept;
	logic        mapped;
	regOp_t      wrStage;
	regOp_t      rdStage1;
	regOp_t      rdStage2;
	integer      seed;
	int          valueErrs;
	int          otherErrs;

	UProc #(.SPI_CLK_DIV(SPI_CLK_DIV), .MAP_REGS(MAP_REGS)) uut (
		.i_sysClk(clk), .i_rstN(rstN),
		.i_spiMISO(spiMiso), .i_smDoPause(doPause),
		.i_coreReq(coreReq), .i_memData(memData),
		.o_spiCLK(spiClk), .o_spiMOSI(spiMosi), .o_spiCSn(spiCsN),
		.o_memReq(memReq), .o_coreRdata(coreRdata), .o_coreRvalid(coreRvalid),
		.o_smIsBooted(isBooted), .o_smIsPaused(isPaused),
		.o_smBootFail(bootFail), .o_gpioPins(gpioPins)
	);

	spiEepromModel #(.DEPTH(DEPTH)) eeprom (
		.i_spiCLK(spiClk), .i_spiMOSI(spiMosi), .i_spiCSn(spiCsN),
		.o_spiMISO(spiMiso)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------------------------
	// Reference model of the core port.
	// ----------------------------------------------------------

	// Taken only when booted and not paused.
	assign accept = isBooted && !isPaused && coreReq.en;
	assign mapped = coreReq.addr[MAP_BASE_BIT];

	always @(posedge clk) begin
		if (!rstN) begin
			bootedQ  <= 1'b0;
			wrCnt    <= 0;
			wrStage  <= '0;
			rdStage1 <= '0;
			rdStage2 <= '0;
			for (int i = 0; i < MAP_REGS; i++) begin
				shadow[i] <= '0;
			end
		end else begin
			bootedQ <= isBooted;
			if (memReq.en && !bootedQ) begin
				wrCnt <= wrCnt + 1;
			end
			// Mapped write lands a cycle after the request.
			wrStage <= {accept && mapped && coreReq.wr, coreReq.addr[IDX_W-1:0], coreReq.data};
			if (wrStage.valid) begin
				shadow[wrStage.idx] <= wrStage.data;
			end
			// Read data two cycles after the request.
			rdStage1 <= {accept && mapped && !coreReq.wr, coreReq.addr[IDX_W-1:0], 16'h0000};
			rdStage2 <= {rdStage1.valid, rdStage1.idx, shadow[rdStage1.idx]};
		end
	end

	// ----------------------------------------------------------
	// Checks.
	// ----------------------------------------------------------

	// Boot copy in order and matching the image.
	assert property (@(posedge clk) disable iff (!rstN)
		memReq.en && !bootedQ |-> wrCnt < expCount && memReq.wr
			&& memReq.addr == 16'(wrCnt) && memReq.data == expWords[wrCnt])
	else valueMismatch("o_memReq addr/data", {$sampled(memReq.addr), $sampled(memReq.data)},
		{16'($sampled(wrCnt)), expWords[$sampled(wrCnt)]});

	assert property (@(posedge clk) disable iff (!rstN)
		$rose(isBooted) |=> wrCnt == expCount)
	else valueMismatch("boot write count", $sampled(wrCnt), expCount);

	assert property (@(posedge clk) disable iff (!rstN)
		$rose(isBooted) |-> bootFail == expFail)
	else valueMismatch("o_smBootFail", $sampled(bootFail), expFail);

	assert property (@(posedge clk) disable iff (!rstN) !$fell(isBooted))
	else protocolFault("o_smIsBooted fell after boot");

	assert property (@(posedge clk) disable iff (!rstN) isBooted |-> spiCsN)
	else protocolFault("SPI chip select low after boot");

	// Core SRAM requests pass unchanged one cycle later.
	assert property (@(posedge clk) disable iff (!rstN)
		accept && !mapped |=> memReq == $past(coreReq))
	else valueMismatch("o_memReq", $sampled(memReq), $past(coreReq));

	// Covers mapped, dropped and paused traffic.
	assert property (@(posedge clk) disable iff (!rstN)
		isBooted && !(accept && !mapped) |=> !memReq.en)
	else protocolFault("SRAM enable without an accepted SRAM request");

	assert property (@(posedge clk) disable iff (!rstN)
		rdStage2.valid |-> coreRvalid && coreRdata == rdStage2.data)
	else valueMismatch("o_coreRvalid/o_coreRdata", {$sampled(coreRvalid), $sampled(coreRdata)},
		{1'b1, $sampled(rdStage2.data)});

	assert property (@(posedge clk) disable iff (!rstN) coreRvalid |-> rdStage2.valid)
	else protocolFault("read valid without an accepted mapped read");

	// SRAM read data reaches the core when no mapped read returns.
	assert property (@(posedge clk) disable iff (!rstN) !coreRvalid |-> coreRdata == memData)
	else valueMismatch("o_coreRdata", $sampled(coreRdata), $sampled(memData));

	assert property (@(posedge clk) disable iff (!rstN) gpioPins == shadow[0])
	else valueMismatch("o_gpioPins", $sampled(gpioPins), $sampled(shadow[0]));

	// Pause entered and left within four cycles.
	assert property (@(posedge clk) disable iff (!rstN)
		(isBooted && doPause)[*5] |-> isPaused)
	else protocolFault("not paused four cycles after the pause request");

	assert property (@(posedge clk) disable iff (!rstN) (!doPause)[*5] |-> !isPaused)
	else protocolFault("still paused four cycles after the pause release");

	// ----------------------------------------------------------
	// Helpers.
	// ----------------------------------------------------------
	task automatic valueMismatch(input string name, input logic [33:0] got,
		input logic [33:0] exp);
		valueErrs++;
		$display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
	endtask

	task automatic protocolFault(input string what);
		otherErrs++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	// Header with the given magic, then the scoreboard words.
	task automatic loadImage(input logic [3:0] magic);
		logic [15:0] hdr;
		hdr = {magic, 12'(WORDS)};
		eeprom.mem[0] = hdr[15:8];
		eeprom.mem[1] = hdr[7:0];
		for (int i = 0; i < WORDS; i++) begin
			eeprom.mem[2 + 2 * i] = expWords[i][15:8];
			eeprom.mem[3 + 2 * i] = expWords[i][7:0];
		end
	endtask

	task automatic applyReset();
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	endtask

	// One request cycle, one idle cycle. Called at a falling edge.
	task automatic coreAccess(input logic wr, input logic [15:0] addr, input logic [15:0] data);
		coreReq = {1'b1, wr, addr, data};
		memData = 16'($random(seed));
		@(negedge clk);
		coreReq = '0;
		@(negedge clk);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Watchdog.
	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("Timeout: boot and core tests did not finish in %0d cycles", LIMIT);
		$display("Testbench failed");
		$finish;
	end

	// ----------------------------------------------------------
	// Stimulus.
	// ----------------------------------------------------------
	initial begin
		seed      = 32'ha51fb534;
		rstN      = 1'b0;
		doPause   = 1'b0;
		coreReq   = '0;
		memData   = 16'h5a5a;
		valueErrs = 0;
		otherErrs = 0;
		for (int i = 0; i < WORDS; i++) begin
			expWords[i] = 16'($random(seed));
		end
		// Tail bytes past the image.
		for (int i = 0; i < DEPTH; i++) begin
			eeprom.mem[i] = 8'(i) ^ 8'h3c;
		end
		loadImage(BOOT_MAGIC);
		expCount = WORDS;
		expFail  = 1'b0;
		applyReset();
		wait (isBooted);
		@(negedge clk);
		// Mapped registers and GPIO.
		coreAccess(1'b1, 16'h8005, 16'h1234);
		coreAccess(1'b1, 16'h8000, 16'hbeef);
		coreAccess(1'b0, 16'h8005, 16'h0000);
		coreAccess(1'b0, 16'h8000, 16'h0000);
		coreAccess(1'b0, 16'h8003, 16'h0000);
		// SRAM side of the core port.
		coreAccess(1'b1, 16'h0123, 16'h4567);
		coreAccess(1'b0, 16'h7ffe, 16'h0000);
		// Traffic while paused is dropped.
		doPause = 1'b1;
		idleCycles(6);
		coreAccess(1'b1, 16'h8000, 16'h0bad);
		coreAccess(1'b1, 16'h0200, 16'h0bad);
		coreAccess(1'b0, 16'h8005, 16'h0000);
		doPause = 1'b0;
		idleCycles(6);
		coreAccess(1'b1, 16'h8000, 16'h600d);
		coreAccess(1'b0, 16'h8000, 16'h0000);
		idleCycles(4);
		// Second boot from a bad header.
		loadImage(4'h5);
		expCount = 0;
		expFail  = 1'b1;
		applyReset();
		wait (isBooted);
		idleCycles(4);
		$display("Errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
		if (valueErrs + otherErrs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/spiEepromModel.sv
// Behavioural SPI EEPROM, mode 0, READ command with a 16-bit address only.
// Reads past DEPTH wrap around. The testbench writes mem directly.
`timescale 1ns/100ps
`default_nettype none

module spiEepromModel import bootPkg::*; #(
	parameter int DEPTH = 64
) (
	input  logic i_spiCLK,
	input  logic i_spiMOSI,
	input  logic i_spiCSn,
	output logic o_spiMISO
);

	logic [7:0]  mem [DEPTH];
	logic [23:0] cmdAddr;
	logic [7:0]  curByte;
	int          riseCnt;
	int          fallCnt;
	int          bitIdx;

	initial begin
		o_spiMISO = 1'b0;
		cmdAddr   = '0;
		riseCnt   = 0;
		fallCnt   = 0;
	end

	// New transfer on select.
	always @(negedge i_spiCSn) begin
		riseCnt = 0;
		fallCnt = 0;
	end

	// Opcode then address, MSB first, on rising edges.
	always @(posedge i_spiCLK) begin
		if (!i_spiCSn && riseCnt < 24) begin
			cmdAddr = {cmdAddr[22:0], i_spiMOSI};
			riseCnt = riseCnt + 1;
		end
	end

	// Data bits leave on falling edges, first one after the last address bit.
	always @(negedge i_spiCLK) begin
		if (!i_spiCSn) begin
			fallCnt = fallCnt + 1;
			if (fallCnt >= 24 && cmdAddr[23:16] == SPI_READ_CMD) begin
				bitIdx    = fallCnt - 24;
				curByte   = mem[(int'(cmdAddr[15:0]) + bitIdx / 8) % DEPTH];
				o_spiMISO = curByte[7 - bitIdx % 8];
			end
		end
	end

	// Output idles low while deselected.
	always @(posedge i_spiCSn) begin
		o_spiMISO = 1'b0;
	end

endmodule

`default_nettype wire

// File: hw/UProc.sv
// Boot and bus subsystem: SPI boot copy into SRAM, then the core port.
// SRAM and GPIO data use separate in and out ports. Reset is synchronous.
`timescale 1ns/100ps
`default_nettype none

module UProc import bootPkg::*; #(
	parameter int SPI_CLK_DIV = 2,
	parameter int MAP_REGS    = 16
) (
	input  logic        i_sysClk,
	input  logic        i_rstN,
	input  logic        i_spiMISO,
	input  logic        i_smDoPause,
	input  memReq_t     i_coreReq,
	input  logic [15:0] i_memData,
	output logic        o_spiCLK,
	output logic        o_spiMOSI,
	output logic        o_spiCSn,
	output memReq_t     o_memReq,
	output logic [15:0] o_coreRdata,
	output logic        o_coreRvalid,
	output logic        o_smIsBooted,
	output logic        o_smIsPaused,
	output logic        o_smBootFail,
	output logic [15:0] o_gpioPins
);

	// ----------------------------------------------------------
	// Stage wires.
	// ----------------------------------------------------------
	spiByte_t                    spiByte;
	logic                        spiEn;
	memReq_t                     bootReq;
	logic                        mapWr;
	logic [$clog2(MAP_REGS)-1:0] mapIdx;
	logic [15:0]                 mapWdata;
	logic [15:0]                 mapRdata;
	logic [15:0]                 ctlRdata;
	logic                        ctlRvalid;

	// EEPROM byte reader.
	SpiReader #(.SPI_CLK_DIV(SPI_CLK_DIV)) SPI_READER (
		.i_sysClk(i_sysClk), .i_rstN(i_rstN),
		.i_spiEn(spiEn), .i_spiMISO(i_spiMISO),
		.o_spiCLK(o_spiCLK), .o_spiMOSI(o_spiMOSI), .o_spiCSn(o_spiCSn),
		.o_byte(spiByte)
	);

	// Image decoder and copier.
	BootImage BOOT_IMAGE (
		.i_sysClk(i_sysClk), .i_rstN(i_rstN),
		.i_byte(spiByte),
		.o_spiEn(spiEn), .o_bootReq(bootReq),
		.o_bootDone(o_smIsBooted), .o_bootFail(o_smBootFail)
	);

	// SRAM bus owner and pause network.
	MemController #(.MAP_REGS(MAP_REGS)) MEM_CTRL (
		.i_sysClk(i_sysClk), .i_rstN(i_rstN),
		.i_bootReq(bootReq), .i_bootDone(o_smIsBooted),
		.i_coreReq(i_coreReq), .i_smDoPause(i_smDoPause),
		.i_mapRdata(mapRdata),
		.o_memReq(o_memReq),
		.o_mapWr(mapWr), .o_mapIdx(mapIdx), .o_mapWdata(mapWdata),
		.o_coreRdata(ctlRdata), .o_coreRvalid(ctlRvalid),
		.o_smIsPaused(o_smIsPaused)
	);

	// Memory-mapped registers.
	MappedRegisters #(.MAP_REGS(MAP_REGS)) MAPPED_REGS (
		.i_sysClk(i_sysClk), .i_rstN(i_rstN),
		.i_wr(mapWr), .i_idx(mapIdx), .i_wdata(mapWdata),
		.o_rdata(mapRdata), .o_gpio(o_gpioPins)
	);

	// Mapped read data when valid, else SRAM read data for the core.
	assign o_coreRdata  = ctlRvalid ? ctlRdata : i_memData;
	assign o_coreRvalid = ctlRvalid;

endmodule

`default_nettype wire

// File: hw/MappedRegisters.sv
// Register bank behind the mapped address region, cleared on reset.
// Read data appears one cycle after the index. Register 0 drives GPIO.
`timescale 1ns/100ps
`default_nettype none

module MappedRegisters #(
	parameter int MAP_REGS = 16
) (
	input  logic                        i_sysClk,
	input  logic                        i_rstN,
	input  logic                        i_wr,
	input  logic [$clog2(MAP_REGS)-1:0] i_idx,
	input  logic [15:0]                 i_wdata,
	output logic [15:0]                 o_rdata,
	output logic [15:0]                 o_gpio
);

	logic [15:0] regs [MAP_REGS];

	// ----------------------------------------------------------
	// Write port.
	// ----------------------------------------------------------
	always_ff @(posedge i_sysClk) begin
		if (!i_rstN) begin
			for (int i = 0; i < MAP_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr) begin
			regs[i_idx] <= i_wdata;
		end
	end

	// ----------------------------------------------------------
	// Read port and GPIO.
	// ----------------------------------------------------------

	// Registered read.
	always_ff @(posedge i_sysClk) begin
		o_rdata <= regs[i_idx];
	end

	// GPIO output register.
	assign o_gpio = regs[0];

endmodule

`default_nettype wire

// File: hw/MemController.sv
// Owns the SRAM bus. Boot requests pass until boot ends, then the core port.
// Core requests while unbooted or paused are dropped, never queued.
`timescale 1ns/100ps
`default_nettype none

module MemController import bootPkg::*; #(
	parameter int MAP_REGS = 16
) (
	input  logic                        i_sysClk,
	input  logic                        i_rstN,
	input  memReq_t                     i_bootReq,
	input  logic                        i_bootDone,
	input  memReq_t                     i_coreReq,
	input  logic                        i_smDoPause,
	input  logic [15:0]                 i_mapRdata,
	output memReq_t                     o_memReq,
	output logic                        o_mapWr,
	output logic [$clog2(MAP_REGS)-1:0] o_mapIdx,
	output logic [15:0]                 o_mapWdata,
	output logic [15:0]                 o_coreRdata,
	output logic                        o_coreRvalid,
	output logic                        o_smIsPaused
);

	localparam int IDX_W = $clog2(MAP_REGS);

	logic syncQ1;
	logic syncQ2;
	logic pauseStartQ;
	logic coreAcc;
	logic mapSel;
	logic rdPend;

	// Core request accepted this cycle.
	assign coreAcc = i_bootDone && !o_smIsPaused && i_coreReq.en;
	// Upper half of the space is the register bank.
	assign mapSel = i_coreReq.addr[MAP_BASE_BIT];

	// Read port data is qualified by o_coreRvalid.
	assign o_coreRdata = i_mapRdata;

	// ----------------------------------------------------------
	// Bus ownership and pause network.
	// ----------------------------------------------------------
	always_ff @(posedge i_sysClk) begin
		if (!i_rstN) begin
			syncQ1       <= 1'b0;
			syncQ2       <= 1'b0;
			pauseStartQ  <= 1'b0;
			o_smIsPaused <= 1'b0;
			o_memReq     <= '0;
			o_mapWr      <= 1'b0;
			rdPend       <= 1'b0;
			o_coreRvalid <= 1'b0;
		end else begin
			// Two-flop synchronizer feeding the pause start flop.
			syncQ1       <= i_smDoPause;
			syncQ2       <= syncQ1;
			pauseStartQ  <= syncQ2;
			o_smIsPaused <= pauseStartQ & i_bootDone;
			if (!i_bootDone) begin
				o_memReq <= i_bootReq;
			end else if (coreAcc && !mapSel) begin
				o_memReq <= i_coreReq;
			end else begin
				o_memReq <= '0;
			end
			o_mapWr <= coreAcc && mapSel && i_coreReq.wr;
			// Read data is ready one cycle after the index.
			rdPend       <= coreAcc && mapSel && !i_coreReq.wr;
			o_coreRvalid <= rdPend;
		end
	end

	// Mapped index and write data.
	always_ff @(posedge i_sysClk) begin
		if (coreAcc && mapSel) begin
			o_mapIdx   <= i_coreReq.addr[IDX_W-1:0];
			o_mapWdata <= i_coreReq.data;
		end
	end

	// Mapped accesses never reach the SRAM pins.
	assert property (@(posedge i_sysClk) disable iff (!i_rstN)
		(o_mapWr || rdPend) |-> !o_memReq.en);

endmodule

`default_nettype wire

// File: hw/BootImage.sv
// Decodes a big-endian boot image: one header word, then data words.
// Data word n is written to SRAM address n. A bad header ends boot with no writes.
`timescale 1ns/100ps
`default_nettype none

module BootImage import bootPkg::*; (
	input  logic     i_sysClk,
	input  logic     i_rstN,
	input  spiByte_t i_byte,
	output logic     o_spiEn,
	output memReq_t  o_bootReq,
	output logic     o_bootDone,
	output logic     o_bootFail
);

	logic [7:0]  hiByte;
	logic        haveHi;
	logic        gotHdr;
	logic [11:0] remain;
	logic [15:0] wordIdx;
	logic        finish;
	bootWord_t   word;

	// Assembled word, valid with the low byte strobe.
	assign word.raw = {hiByte, i_byte.data};

	// High byte holding register.
	always_ff @(posedge i_sysClk) begin
		if (i_byte.valid && !haveHi) begin
			hiByte <= i_byte.data;
		end
	end

	// ----------------------------------------------------------
	// Header check, copy counter and request generation.
	// ----------------------------------------------------------
	always_ff @(posedge i_sysClk) begin
		if (!i_rstN) begin
			o_spiEn    <= 1'b0;
			haveHi     <= 1'b0;
			gotHdr     <= 1'b0;
			remain     <= '0;
			wordIdx    <= '0;
			finish     <= 1'b0;
			o_bootDone <= 1'b0;
			o_bootFail <= 1'b0;
			o_bootReq  <= '0;
		end else begin
			// Done follows the decision by one cycle.
			o_bootDone   <= finish;
			o_spiEn      <= !finish;
			o_bootReq.en <= 1'b0;
			o_bootReq.wr <= 1'b0;
			if (i_byte.valid && !finish) begin
				if (!haveHi) begin
					haveHi <= 1'b1;
				end else begin
					haveHi <= 1'b0;
					if (!gotHdr) begin
						gotHdr <= 1'b1;
						if (word.hdr.magic != BOOT_MAGIC) begin
							// Bad image, nothing is copied.
							o_bootFail <= 1'b1;
							finish     <= 1'b1;
							o_spiEn    <= 1'b0;
						end else if (word.hdr.count == 12'd0) begin
							finish  <= 1'b1;
							o_spiEn <= 1'b0;
						end else begin
							remain <= word.hdr.count;
						end
					end else begin
						// Data word becomes one SRAM write.
						o_bootReq.en   <= 1'b1;
						o_bootReq.wr   <= 1'b1;
						o_bootReq.addr <= wordIdx;
						o_bootReq.data <= word.raw;
						wordIdx        <= wordIdx + 1'b1;
						remain         <= remain - 1'b1;
						if (remain == 12'd1) begin
							finish  <= 1'b1;
							o_spiEn <= 1'b0;
						end
					end
				end
			end
		end
	end

	// No copy request once boot has ended.
	assert property (@(posedge i_sysClk) disable iff (!i_rstN)
		o_bootDone |=> !o_bootReq.en);

endmodule

`default_nettype wire

// File: hw/SpiReader.sv
// Reads one continuous stream from address 0 of an SPI EEPROM (mode 0).
// SPI_CLK_DIV must be at least 1. A byte is strobed every 16*SPI_CLK_DIV cycles.
`timescale 1ns/100ps
`default_nettype none

module SpiReader import bootPkg::*; #(
	parameter int SPI_CLK_DIV = 2
) (
	input  logic     i_sysClk,
	input  logic     i_rstN,
	input  logic     i_spiEn,
	input  logic     i_spiMISO,
	output logic     o_spiCLK,
	output logic     o_spiMOSI,
	output logic     o_spiCSn,
	output spiByte_t o_byte
);

	// Divider counter width, safe for a divide of 1.
	localparam int DIV_W = $clog2(SPI_CLK_DIV + 1);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_CMD,
		PH_ADDR,
		PH_STREAM
	} phase_t;

	phase_t             phase;
	logic [DIV_W-1:0]   divCnt;
	logic [23:0]        cmdShift;
	logic [7:0]         rxShift;
	logic [4:0]         bitCnt;
	logic               spiEnQ;
	logic               halfTick;
	logic               riseTick;
	logic               fallTick;

	// ----------------------------------------------------------
	// SPI clock edge generation.
	// ----------------------------------------------------------

	// End of one half-period.
	assign halfTick = (divCnt == DIV_W'(SPI_CLK_DIV - 1));
	// Edge about to happen on the SPI clock.
	assign riseTick = halfTick && !o_spiCLK;
	assign fallTick = halfTick && o_spiCLK;

	// Command and address leave MSB first.
	assign o_spiMOSI = cmdShift[23];

	// ----------------------------------------------------------
	// Phase FSM and shifters.
	// ----------------------------------------------------------
	always_ff @(posedge i_sysClk) begin
		if (!i_rstN) begin
			phase    <= PH_IDLE;
			o_spiCSn <= 1'b1;
			o_spiCLK <= 1'b0;
			divCnt   <= '0;
			bitCnt   <= '0;
			cmdShift <= '0;
			rxShift  <= '0;
			spiEnQ   <= 1'b0;
			o_byte   <= '0;
		end else begin
			spiEnQ       <= i_spiEn;
			o_byte.valid <= 1'b0;
			if (phase != PH_IDLE && !i_spiEn) begin
				// Enable dropped, deselect and park clock low.
				phase    <= PH_IDLE;
				o_spiCSn <= 1'b1;
				o_spiCLK <= 1'b0;
			end else if (phase == PH_IDLE) begin
				// Start only on a rising enable.
				if (i_spiEn && !spiEnQ) begin
					phase    <= PH_CMD;
					o_spiCSn <= 1'b0;
					divCnt   <= '0;
					bitCnt   <= '0;
					cmdShift <= {SPI_READ_CMD, 16'h0000};
				end
			end else begin
				if (halfTick) begin
					divCnt   <= '0;
					o_spiCLK <= ~o_spiCLK;
				end else begin
					divCnt <= divCnt + 1'b1;
				end
				// MOSI moves on the falling edge.
				if (fallTick) begin
					cmdShift <= {cmdShift[22:0], 1'b0};
				end
				// Bits are counted on the rising edge.
				if (riseTick) begin
					bitCnt <= bitCnt + 1'b1;
					case (phase)
						PH_CMD: begin
							if (bitCnt == 5'd7) begin
								phase <= PH_ADDR;
							end
						end
						PH_ADDR: begin
							// Last address bit, data follows.
							if (bitCnt == 5'd23) begin
								phase  <= PH_STREAM;
								bitCnt <= '0;
							end
						end
						default: begin
							rxShift <= {rxShift[6:0], i_spiMISO};
							if (bitCnt == 5'd7) begin
								o_byte.valid <= 1'b1;
								o_byte.data  <= {rxShift[6:0], i_spiMISO};
								bitCnt       <= '0;
							end
						end
					endcase
				end
			end
		end
	end

	// Byte strobes only inside a selected, full byte period.
	assert property (@(posedge i_sysClk) disable iff (!i_rstN)
		o_byte.valid |-> !o_spiCSn && $past(!o_spiCSn, 16 * SPI_CLK_DIV));

endmodule

`default_nettype wire

// File: hw/bootPkg.sv
// Types and constants shared by the boot and memory path.
// Field order in memReq_t is fixed and is packed from the MSB down.
`default_nettype none

package bootPkg;

	// ----------------------------------------------------------
	// Image format and SPI constants.
	// ----------------------------------------------------------

	// Magic nibble of a valid image header.
	localparam logic [3:0] BOOT_MAGIC = 4'hA;
	// EEPROM read opcode.
	localparam logic [7:0] SPI_READ_CMD = 8'h03;
	// Core address bit that selects the mapped registers.
	localparam int MAP_BASE_BIT = 15;

	// ----------------------------------------------------------
	// Bus types.
	// ----------------------------------------------------------

	// One received SPI byte with its strobe.
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} spiByte_t;

	// Memory request, shared by the boot copier and the core port.
	typedef struct packed {
		logic        en;
		logic        wr;
		logic [15:0] addr;
		logic [15:0] data;
	} memReq_t;

	// Header word layout.
	typedef struct packed {
		logic [3:0]  magic;
		logic [11:0] count;
	} bootHdr_t;

	// First image word is a header, the rest are raw data.
	typedef union packed {
		bootHdr_t    hdr;
		logic [15:0] raw;
	} bootWord_t;

endpackage

`default_nettype wire
